// ==== Bender.yml ====
package:
  name: eeprom_ctrl

sources:
  - source/eeprom_pkg.sv
  - source/i2c_byte_engine.sv
  - source/eeprom_sequencer.sv
  - source/eeprom_ctrl.sv
  - target: test
    files:
      - testbench/eeprom_model.sv
      - testbench/eeprom_ctrl_assert.sv
      - testbench/tb_eeprom_ctrl.sv

// ==== eeprom_ctrl.f ====
source/eeprom_pkg.sv
source/i2c_byte_engine.sv
source/eeprom_sequencer.sv
source/eeprom_ctrl.sv
testbench/eeprom_model.sv
testbench/eeprom_ctrl_assert.sv
testbench/tb_eeprom_ctrl.sv

// ==== source/eeprom_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module eeprom_ctrl
    import eeprom_pkg::*;
(
    input  wire logic    CLK,
    input  wire logic    RESET,
    input  wire wb_req_t wb_req,
    output wb_rsp_t      wb_rsp,
    output logic         scl,
    output logic         sda_oe,
    input  wire logic    sda_in
);

    byte_cmd_t byte_cmd;
    byte_rsp_t byte_rsp;

    // transaction level
    eeprom_sequencer u_sequencer (
        .CLK      (CLK),
        .RESET    (RESET),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .byte_cmd (byte_cmd),
        .byte_rsp (byte_rsp)
    );

    // bit level, open drain sda
    i2c_byte_engine u_byte_engine (
        .CLK      (CLK),
        .RESET    (RESET),
        .byte_cmd (byte_cmd),
        .byte_rsp (byte_rsp),
        .scl      (scl),
        .sda_oe   (sda_oe),
        .sda_in   (sda_in)
    );

endmodule

`default_nettype wire

// ==== source/eeprom_pkg.sv ====
`default_nettype none

package eeprom_pkg;

    localparam int ADDR_W = 11;        // 2 KB array
    localparam int DATA_W = 8;

    // CLK cycles per quarter of an SCL period
    localparam int SCL_QUARTER = 4;
    localparam int QCNT_W      = $clog2(SCL_QUARTER);

    localparam logic [3:0] DEV_CODE = 4'b1010;   // control byte prefix

    typedef enum logic [1:0] {
        START = 2'd0,
        STOP  = 2'd1,
        WRITE = 2'd2,
        READ  = 2'd3
    } byte_op_t;

    typedef struct packed {
        logic              valid;
        byte_op_t          op;
        logic [DATA_W-1:0] data;
        logic              nack_last;   // master NACKs the read byte
    } byte_cmd_t;

    typedef struct packed {
        logic              done;
        logic              nack;
        logic [DATA_W-1:0] data;
    } byte_rsp_t;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic              err;
        logic [DATA_W-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== source/eeprom_sequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module eeprom_sequencer
    import eeprom_pkg::*;
(
    input  wire logic      CLK,
    input  wire logic      RESET,
    input  wire wb_req_t   wb_req,
    output wb_rsp_t        wb_rsp,
    output byte_cmd_t      byte_cmd,
    input  wire byte_rsp_t byte_rsp
);

    typedef enum logic [9:0] {
        S_IDLE     = 10'b00_0000_0001,
        S_START    = 10'b00_0000_0010,
        S_CTRL_WR  = 10'b00_0000_0100,
        S_ADDR     = 10'b00_0000_1000,
        S_DATA_WR  = 10'b00_0001_0000,
        S_RD_START = 10'b00_0010_0000,
        S_CTRL_RD  = 10'b00_0100_0000,
        S_DATA_RD  = 10'b00_1000_0000,
        S_STOP     = 10'b01_0000_0000,
        S_DONE     = 10'b10_0000_0000
    } state_t;

    state_t            state;
    logic              armed;       // stb seen low since last accept
    logic              nack_seen;
    logic              ack_q;
    logic              err_q;

    logic [ADDR_W-1:0] adr_q;
    logic [DATA_W-1:0] dat_q;
    logic              we_q;
    logic [DATA_W-1:0] rd_q;

    logic              req;
    logic [DATA_W-1:0] ctrl_wr;
    logic [DATA_W-1:0] ctrl_rd;

    assign req     = wb_req.cyc && wb_req.stb && armed;
    assign ctrl_wr = {DEV_CODE, adr_q[ADDR_W-1:DATA_W], 1'b0};   // page bits in control byte
    assign ctrl_rd = {DEV_CODE, adr_q[ADDR_W-1:DATA_W], 1'b1};

    function automatic byte_cmd_t mk_cmd(input byte_op_t op, input logic [DATA_W-1:0] data,
                                         input logic nack_last);
        byte_cmd_t c;
        c.valid     = 1'b1;
        c.op        = op;
        c.data      = data;
        c.nack_last = nack_last;
        return c;
    endfunction

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= S_IDLE;
            armed     <= 1'b0;
            nack_seen <= 1'b0;
            ack_q     <= 1'b0;
            err_q     <= 1'b0;
            byte_cmd  <= '0;
        end
        else
        begin
            byte_cmd.valid <= 1'b0;
            ack_q          <= 1'b0;
            err_q          <= 1'b0;
            if (!wb_req.stb)
                armed <= 1'b1;

            if (byte_rsp.done && byte_rsp.nack)
            begin
                // device refused a byte, close the bus
                nack_seen <= 1'b1;
                byte_cmd  <= mk_cmd(STOP, '0, 1'b0);
                state     <= S_STOP;
            end
            else
            begin
                case (state)
                    S_IDLE:
                        if (req)
                        begin
                            armed     <= 1'b0;
                            nack_seen <= 1'b0;
                            byte_cmd  <= mk_cmd(START, '0, 1'b0);
                            state     <= S_START;
                        end
                    S_START:
                        if (byte_rsp.done)
                        begin
                            byte_cmd <= mk_cmd(WRITE, ctrl_wr, 1'b0);
                            state    <= S_CTRL_WR;
                        end
                    S_CTRL_WR:
                        if (byte_rsp.done)
                        begin
                            byte_cmd <= mk_cmd(WRITE, adr_q[DATA_W-1:0], 1'b0);
                            state    <= S_ADDR;
                        end
                    S_ADDR:
                        if (byte_rsp.done)
                        begin
                            if (we_q)
                            begin
                                byte_cmd <= mk_cmd(WRITE, dat_q, 1'b0);
                                state    <= S_DATA_WR;
                            end
                            else
                            begin
                                byte_cmd <= mk_cmd(START, '0, 1'b0);   // repeated start
                                state    <= S_RD_START;
                            end
                        end
                    S_RD_START:
                        if (byte_rsp.done)
                        begin
                            byte_cmd <= mk_cmd(WRITE, ctrl_rd, 1'b0);
                            state    <= S_CTRL_RD;
                        end
                    S_CTRL_RD:
                        if (byte_rsp.done)
                        begin
                            byte_cmd <= mk_cmd(READ, '0, 1'b1);   // single byte, NACK it
                            state    <= S_DATA_RD;
                        end
                    S_DATA_WR, S_DATA_RD:
                        if (byte_rsp.done)
                        begin
                            byte_cmd <= mk_cmd(STOP, '0, 1'b0);
                            state    <= S_STOP;
                        end
                    S_STOP:
                        if (byte_rsp.done)
                        begin
                            ack_q <= !nack_seen;
                            err_q <= nack_seen;
                            state <= S_DONE;
                        end
                    S_DONE:
                        state <= S_IDLE;
                    default:
                        state <= S_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == S_IDLE && req)
        begin
            adr_q <= wb_req.adr;
            dat_q <= wb_req.dat;
            we_q  <= wb_req.we;
        end
        if (state == S_DATA_RD && byte_rsp.done)
            rd_q <= byte_rsp.data;
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.err = err_q;
    assign wb_rsp.dat = rd_q;

endmodule

`default_nettype wire

// ==== source/i2c_byte_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module i2c_byte_engine
    import eeprom_pkg::*;
(
    input  wire logic      CLK,
    input  wire logic      RESET,
    input  wire byte_cmd_t byte_cmd,
    output byte_rsp_t      byte_rsp,
    output logic           scl,
    output logic           sda_oe,
    input  wire logic      sda_in
);

    logic              busy;
    logic [1:0]        phase;      // 0,1 scl low / 2,3 scl high
    logic [QCNT_W-1:0] q_cnt;
    logic [3:0]        bit_cnt;    // 0..7 data, 8 ack slot
    logic              nack_q;

    byte_op_t          op_q;
    logic              nack_last_q;
    logic [DATA_W-1:0] shreg;

    logic              q_end;
    logic              ack_slot;
    logic              last_bit;
    logic              sda_next;

    assign q_end    = (q_cnt == QCNT_W'(SCL_QUARTER - 1));
    assign ack_slot = (bit_cnt == 4'(DATA_W));
    assign last_bit = (op_q == START) || (op_q == STOP) || ack_slot;

    // level driven in the second low quarter
    always_comb
    begin
        case (op_q)
            START:   sda_next = 1'b0;     // release first, repeated start needs SDA high
            STOP:    sda_next = 1'b1;     // hold low, released while scl high
            WRITE:   sda_next = ack_slot ? 1'b0 : ~shreg[DATA_W-1];
            default: sda_next = ack_slot ? ~nack_last_q : 1'b0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            phase   <= 2'd0;
            q_cnt   <= '0;
            bit_cnt <= '0;
            nack_q  <= 1'b0;
            scl     <= 1'b1;
            sda_oe  <= 1'b0;
        end
        else if (!busy)
        begin
            if (byte_cmd.valid)
            begin
                busy    <= 1'b1;
                phase   <= 2'd0;
                q_cnt   <= '0;
                bit_cnt <= '0;
                nack_q  <= 1'b0;
                scl     <= 1'b0;
            end
        end
        else if (!q_end)
        begin
            q_cnt <= q_cnt + 1'b1;
        end
        else
        begin
            q_cnt <= '0;
            phase <= phase + 2'd1;
            case (phase)
                2'd0:
                begin
                    sda_oe <= sda_next;   // scl already low for a quarter
                end
                2'd1:
                begin
                    scl <= 1'b1;
                end
                2'd2:
                begin
                    // middle of scl high
                    if (op_q == START)
                        sda_oe <= 1'b1;   // start condition
                    else if (op_q == STOP)
                        sda_oe <= 1'b0;   // stop condition
                    else if (op_q == WRITE && ack_slot)
                        nack_q <= sda_in;
                end
                default:
                begin
                    if (last_bit)
                    begin
                        busy <= 1'b0;     // scl stays high until next op
                    end
                    else
                    begin
                        bit_cnt <= bit_cnt + 4'd1;
                        scl     <= 1'b0;
                    end
                end
            endcase
        end
    end

    // operation payload
    always_ff @(posedge CLK)
    begin
        if (!busy && byte_cmd.valid)
        begin
            op_q        <= byte_cmd.op;
            nack_last_q <= byte_cmd.nack_last;
            shreg       <= byte_cmd.data;
        end
        else if (busy && q_end && phase == 2'd2 && !ack_slot
                 && (op_q == WRITE || op_q == READ))
        begin
            // msb first both ways
            shreg <= {shreg[DATA_W-2:0], (op_q == READ) ? sda_in : 1'b0};
        end
    end

    assign byte_rsp.done = busy && q_end && (phase == 2'd3) && last_bit;
    assign byte_rsp.nack = nack_q;
    assign byte_rsp.data = shreg;

endmodule

`default_nettype wire

// ==== testbench/eeprom_ctrl_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module eeprom_ctrl_assert
    import eeprom_pkg::*;
(
    input wire logic      CLK,
    input wire logic      RESET,
    input wire wb_req_t   wb_req,
    input wire wb_rsp_t   wb_rsp,
    input wire logic      scl,
    input wire logic      sda_oe,
    input wire byte_cmd_t byte_cmd
);

    int       assert_fails = 0;
    byte_op_t last_op;
    logic     bus_cond;

    always_ff @(posedge CLK)
    begin
        if (RESET)
            last_op <= STOP;
        else if (byte_cmd.valid)
            last_op <= byte_cmd.op;
    end

    assign bus_cond = (last_op == START) || (last_op == STOP);

    a_one_term: assert property (@(posedge CLK) disable iff (RESET)
        !(wb_rsp.ack && wb_rsp.err))
    else
    begin
        assert_fails++;
        $error("ack and err high in the same cycle");
    end

    a_term_in_req: assert property (@(posedge CLK) disable iff (RESET)
        (wb_rsp.ack || wb_rsp.err) |-> (wb_req.cyc && wb_req.stb))
    else
    begin
        assert_fails++;
        $error("ack or err without cyc and stb");
    end

    a_sda_scl_low: assert property (@(posedge CLK) disable iff (RESET)
        $changed(sda_oe) |-> (!scl || bus_cond))
    else
    begin
        assert_fails++;
        $error("sda_oe moved while scl high outside start or stop");
    end

endmodule

bind eeprom_ctrl eeprom_ctrl_assert u_assert (
    .CLK      (CLK),
    .RESET    (RESET),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp),
    .scl      (scl),
    .sda_oe   (sda_oe),
    .byte_cmd (byte_cmd)
);

`default_nettype wire

// ==== testbench/eeprom_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module eeprom_model
    import eeprom_pkg::*;
(
    input  wire logic scl,
    inout  wire       sda,
    input  wire logic respond_en
);

    typedef enum {M_IDLE, M_CTRL, M_ADDR, M_WDATA, M_RDATA} mstate_t;

    logic [DATA_W-1:0] mem [0:2**ADDR_W-1];
    mstate_t           state = M_IDLE;
    int                bit_cnt = 0;
    logic [DATA_W-1:0] sh = '0;
    logic [DATA_W-1:0] out_byte = '0;
    logic [ADDR_W-1:0] addr = '0;
    logic [2:0]        page = '0;
    logic              drive_low = 1'b0;
    logic              in_ack = 1'b0;     // ack slot of the current byte
    logic              master_ack = 1'b0;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < 2**ADDR_W; i++)
            mem[i] = 8'hFF;   // erased
    end

    // start condition
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            state     = M_CTRL;
            bit_cnt   = 0;
            in_ack    = 1'b0;
            drive_low = 1'b0;
        end
    end

    // stop condition
    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            state     = M_IDLE;
            in_ack    = 1'b0;
            drive_low = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (state != M_IDLE && in_ack)
            master_ack = (sda === 1'b0);
        else if (state != M_IDLE)
        begin
            if (state != M_RDATA)
                sh = {sh[DATA_W-2:0], sda === 1'b1};
            bit_cnt = bit_cnt + 1;
        end
    end

    always @(negedge scl)
    begin
        if (in_ack)
        begin
            in_ack    = 1'b0;
            drive_low = 1'b0;
            bit_cnt   = 0;
            case (state)
                M_CTRL:
                    state = sh[0] ? M_RDATA : M_ADDR;
                M_ADDR:
                begin
                    addr  = {page, sh};
                    state = M_WDATA;
                end
                M_WDATA:
                    mem[addr] = sh;
                M_RDATA:
                    if (master_ack)
                        addr = addr + 1'b1;
                    else
                        state = M_IDLE;   // wait for stop
                default:
                    state = M_IDLE;
            endcase
            if (state == M_RDATA)
            begin
                out_byte  = mem[addr];
                drive_low = !out_byte[DATA_W-1];
            end
        end
        else if (state == M_RDATA)
        begin
            if (bit_cnt == DATA_W)
            begin
                drive_low = 1'b0;   // master ack slot
                in_ack    = 1'b1;
            end
            else
                drive_low = !out_byte[DATA_W-1-bit_cnt];
        end
        else if (state != M_IDLE && bit_cnt == DATA_W)
        begin
            if (!respond_en || (state == M_CTRL && sh[7:4] != DEV_CODE))
                state = M_IDLE;   // silent, master sees NACK
            else
            begin
                if (state == M_CTRL && !sh[0])
                    page = sh[3:1];
                drive_low = 1'b1;
                in_ack    = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_eeprom_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_eeprom_ctrl
    import eeprom_pkg::*;
();

    localparam int TIMEOUT = 2000;
    localparam int N_RAND  = 20;

    logic    CLK;
    logic    RESET;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic    scl;
    logic    sda_oe;
    logic    respond_en;
    tri1     sda;

    logic [DATA_W-1:0] shadow [0:2**ADDR_W-1];
    logic [ADDR_W-1:0] addr_list [0:N_RAND-1];
    integer            seed = 32'ha026;
    int                checks = 0;
    int                value_errors = 0;
    int                other_errors = 0;

    // request in flight
    logic              pending = 1'b0;
    logic              exp_err = 1'b0;
    logic              exp_read = 1'b0;
    logic [ADDR_W-1:0] exp_adr = '0;
    logic [DATA_W-1:0] exp_dat = '0;

    assign sda = sda_oe ? 1'b0 : 1'bz;   // open drain

    eeprom_ctrl u_eeprom_ctrl (
        .CLK    (CLK),
        .RESET  (RESET),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .scl    (scl),
        .sda_oe (sda_oe),
        .sda_in (sda)
    );

    eeprom_model u_eeprom_model (
        .scl        (scl),
        .sda        (sda),
        .respond_en (respond_en)
    );

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // bytes never written read back erased
    function automatic logic [DATA_W-1:0] expect_read(input logic [ADDR_W-1:0] addr);
        return shadow[addr];
    endfunction

    always @(negedge CLK)
    begin
        if (!RESET && (wb_rsp.ack || wb_rsp.err))
        begin
            checks++;
            if (!pending)
            begin
                $display("ERROR %0t: ack or err with no request outstanding", $time);
                other_errors++;
            end
            else if (wb_rsp.err !== exp_err)
            begin
                $display("FAIL %0t: address %h ended with err=%b, expected err=%b",
                         $time, exp_adr, wb_rsp.err, exp_err);
                value_errors++;
            end
            else if (exp_read && !exp_err && wb_rsp.dat !== exp_dat)
            begin
                $display("FAIL %0t: read of %h returned %h, expected %h",
                         $time, exp_adr, wb_rsp.dat, exp_dat);
                value_errors++;
            end
            pending = 1'b0;
        end
    end

    task automatic finish_run();
        int fails;
        fails = value_errors + other_errors + u_eeprom_ctrl.u_assert.assert_fails;
        $display("checks: %0d, value errors: %0d, other errors: %0d, assertion failures: %0d",
                 checks, value_errors, other_errors, u_eeprom_ctrl.u_assert.assert_fails);
        if (fails == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    endtask

    task automatic bus_cycle(input logic we, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] data, input logic expect_err,
                             input int hold);
        int cycles;
        cycles = 0;
        @(posedge CLK);
        #1;
        exp_err    = expect_err;
        exp_read   = !we;
        exp_adr    = addr;
        exp_dat    = expect_read(addr);
        pending    = 1'b1;
        wb_req.we  = we;
        wb_req.adr = addr;
        wb_req.dat = data;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        @(negedge CLK);
        while (!(wb_rsp.ack || wb_rsp.err) && cycles < TIMEOUT)
        begin
            @(negedge CLK);
            cycles++;
        end
        if (!(wb_rsp.ack || wb_rsp.err))
        begin
            $display("timeout: %s of address %h got no ack or err within %0d cycles",
                     we ? "write" : "read", addr, TIMEOUT);
            other_errors++;
            finish_run();
        end
        else
        begin
            if (we && !expect_err)
                shadow[addr] = data;
            repeat (hold) @(posedge CLK);   // stb held past termination
            @(posedge CLK);
            #1;
            wb_req.cyc = 1'b0;
            wb_req.stb = 1'b0;
        end
    endtask

    task automatic wb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic expect_err, input int hold);
        bus_cycle(1'b1, addr, data, expect_err, hold);
    endtask

    task automatic wb_read(input logic [ADDR_W-1:0] addr, input logic expect_err,
                           input int hold);
        bus_cycle(1'b0, addr, '0, expect_err, hold);
    endtask

    initial
    begin
        logic [ADDR_W-1:0] tmp;
        logic [DATA_W-1:0] low_byte;
        int                j;
        RESET      = 1'b1;
        respond_en = 1'b1;
        wb_req     = '0;
        for (int i = 0; i < 2**ADDR_W; i++)
            shadow[i] = 8'hFF;
        repeat (3) @(posedge CLK);
        #1;
        RESET = 1'b0;
        @(negedge CLK);
        checks++;
        if (scl !== 1'b1 || sda_oe !== 1'b0 || wb_rsp.ack !== 1'b0 || wb_rsp.err !== 1'b0)
        begin
            $display("FAIL %0t: after reset scl=%b sda_oe=%b ack=%b err=%b",
                     $time, scl, sda_oe, wb_rsp.ack, wb_rsp.err);
            value_errors++;
        end

        wb_write(11'h123, 8'h5A, 1'b0, 0);
        wb_read(11'h123, 1'b0, 0);

        // every page, four pages share each low byte, never 8'hFF
        for (int i = 0; i < N_RAND; i++)
        begin
            if (i % 4 == 0)
                low_byte = 8'({$random(seed)} % 255);
            addr_list[i] = {3'(i % 8), low_byte};
            wb_write(addr_list[i], 8'($random(seed)), 1'b0, 0);
        end
        for (int i = N_RAND - 1; i > 0; i--)
        begin
            j            = {$random(seed)} % (i + 1);
            tmp          = addr_list[i];
            addr_list[i] = addr_list[j];
            addr_list[j] = tmp;
        end
        for (int i = 0; i < N_RAND; i++)
            wb_read(addr_list[i], 1'b0, 0);

        wb_read(11'h7FF, 1'b0, 0);   // never written

        @(posedge CLK);
        #1;
        respond_en = 1'b0;
        wb_write(addr_list[0], ~expect_read(addr_list[0]), 1'b1, 0);
        wb_read(addr_list[0], 1'b1, 0);
        @(posedge CLK);
        #1;
        respond_en = 1'b1;
        wb_read(addr_list[0], 1'b0, 0);

        wb_write(11'h456, 8'hC3, 1'b0, 6);
        wb_read(11'h456, 1'b0, 6);
        wb_read(11'h123, 1'b0, 0);

        finish_run();
    end

endmodule

`default_nettype wire
